//--- logic/tpl_pkg.sv
// ********************
// JESD204 DAC transport layer package
// Geometry, sample and lane types, source select codes and PN seeds
// shared by the PN generator, the channels and the top level
// ********************

package tpl_pkg;

  // ********************
  // Datapath geometry
  // ********************

  localparam int num_channels     = 2;
  localparam int num_lanes        = 2;
  localparam int samples_per_beat = 2;
  localparam int sample_width     = 16;
  localparam int lane_width       = 32;
  localparam int octet_width      = 8;

  // Bits of one channel in one clock
  localparam int beat_width = samples_per_beat * sample_width;

  // ********************
  // PN generators
  // ********************

  localparam int pn7_len  = 7;
  localparam int pn15_len = 15;

  // Restart values, all ones
  localparam logic [pn7_len-1:0]  pn_seed7  = '1;
  localparam logic [pn15_len-1:0] pn_seed15 = '1;

  // ********************
  // Types
  // ********************

  typedef logic [sample_width-1:0] sample_t;
  typedef logic [lane_width-1:0]   lane_t;

  // Two samples of one channel, s0 is the older one and sits in the MSBs
  typedef struct packed {
    sample_t s0;
    sample_t s1;
  } beat_t;

  // One beat of each sequence, fanned out to every channel
  typedef struct packed {
    beat_t pn7;
    beat_t pn15;
  } pn_beat_t;

  // Channel source select, codes above sel_off act as sel_off
  typedef enum logic [2:0] {
    sel_zero    = 3'd0,
    sel_pattern = 3'd1,
    sel_dma     = 3'd2,
    sel_pn7     = 3'd3,
    sel_pn15    = 3'd4,
    sel_off     = 3'd5
  } data_sel_e;

endpackage

//--- logic/tpl_pn_gen.sv
// ********************
// Shared PN7 / PN15 generator
// Two Fibonacci LFSRs stepped one beat (32 bits) per advancing clock,
// output MSB first as two samples per sequence, reloaded while sync is high
// ********************

`timescale 1ns/1ps

module tpl_pn_gen
  import tpl_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     sync,
  input  logic     advance,
  output pn_beat_t pn
);

  logic [pn7_len-1:0]    pn7_state;
  logic [pn15_len-1:0]   pn15_state;
  logic [pn15_len-1:0]   pn7_run;
  logic [pn15_len-1:0]   pn15_run;
  logic [beat_width-1:0] pn7_bits;
  logic [beat_width-1:0] pn15_bits;

  // ********************
  // LFSR stepping
  // ********************

  // Taps x^len + x^(len-1) + 1, state carried in the wider PN15 vector
  // Upper bits above len are never read, the caller truncates them
  function automatic void lfsr_run(
    input  logic [pn15_len-1:0]   state_in,
    input  int                    len,
    output logic [pn15_len-1:0]   state_out,
    output logic [beat_width-1:0] bits
  );
    logic [pn15_len-1:0] s;
    logic                fb;
    s    = state_in;
    bits = '0;
    for (int i = 0; i < beat_width; i++) begin
      fb = s[len-1] ^ s[len-2];
      s  = {s[pn15_len-2:0], fb};
      // First new bit lands in the MSB of s0
      bits[beat_width-1-i] = fb;
    end
    state_out = s;
  endfunction

  always_comb begin
    lfsr_run(pn15_len'(pn7_state), pn7_len, pn7_run, pn7_bits);
    lfsr_run(pn15_state, pn15_len, pn15_run, pn15_bits);
  end

  // Output is the beat that the current state will produce
  assign pn.pn7  = pn7_bits;
  assign pn.pn15 = pn15_bits;

  // ********************
  // State registers
  // ********************

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pn7_state  <= pn_seed7;
      pn15_state <= pn_seed15;
    end else if (sync) begin
      pn7_state  <= pn_seed7;
      pn15_state <= pn_seed15;
    end else if (advance) begin
      pn7_state  <= pn7_run[pn7_len-1:0];
      pn15_state <= pn15_run;
    end
  end

  // LFSR lockup would show as an all-zero beat
  a_pn_nonzero: assert property (
    @(posedge clk) disable iff (!rst_n)
    (pn.pn7 != '0) && (pn.pn15 != '0)
  );

endmodule

//--- logic/tpl_dac_channel.sv
// ********************
// DAC transport channel
// Picks the sample source, converts offset binary to two's complement,
// registers one beat per clock and holds it while the link stalls
// ********************

`timescale 1ns/1ps

module tpl_dac_channel
  import tpl_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      ready,
  input  data_sel_e data_sel,
  input  logic      format,
  input  sample_t   pat_0,
  input  sample_t   pat_1,
  input  beat_t     dma_data,
  input  pn_beat_t  pn,
  output logic      dma_req,
  output logic      enable,
  output beat_t     data
);

  // Beat from the selected source, before format conversion
  beat_t beat_src;
  // Beat after format conversion, next value of the output register
  beat_t beat_fmt;
  // High when the source carries samples, so format applies
  logic  src_live;

  // ********************
  // Source selection
  // ********************

  always_comb begin
    beat_src = '0;
    src_live = 1'b0;
    enable   = 1'b1;
    dma_req  = 1'b0;
    case (data_sel)
      sel_zero: begin
        // Zero samples, channel stays enabled
        src_live = 1'b0;
      end
      sel_pattern: begin
        beat_src.s0 = pat_0;
        beat_src.s1 = pat_1;
        src_live    = 1'b1;
      end
      sel_dma: begin
        beat_src = dma_data;
        src_live = 1'b1;
        // DMA is only asked for data when the beat is taken
        dma_req  = ready;
      end
      sel_pn7: begin
        beat_src = pn.pn7;
        src_live = 1'b1;
      end
      sel_pn15: begin
        beat_src = pn.pn15;
        src_live = 1'b1;
      end
      default: begin
        // sel_off and unused codes
        enable = 1'b0;
      end
    endcase
  end

  // ********************
  // Format conversion
  // ********************

  // Offset binary to two's complement is an MSB flip
  always_comb begin
    beat_fmt = beat_src;
    if (format && src_live) begin
      beat_fmt.s0[sample_width-1] = ~beat_src.s0[sample_width-1];
      beat_fmt.s1[sample_width-1] = ~beat_src.s1[sample_width-1];
    end
  end

  // ********************
  // Output register
  // ********************

  // Advances only with the link, holds the last beat otherwise
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      data <= '0;
    end else if (ready) begin
      data <= beat_fmt;
    end
  end

  // A DMA request is only made in a taking cycle
  a_dma_taken: assert property (
    @(posedge clk) disable iff (!rst_n)
    dma_req |-> ready
  );

endmodule

//--- logic/tpl_dac_core.sv
// ********************
// JESD204 DAC transport layer, top level
// Shared PN generator, one channel per converter, octet interleaving
// of all channel beats onto the lanes and the link valid flag
// ********************

`timescale 1ns/1ps

module tpl_dac_core
  import tpl_pkg::*;
(
  input  logic                         clk,
  input  logic                         rst_n,

  // DMA side
  input  beat_t     [num_channels-1:0] dma_data,
  output logic      [num_channels-1:0] dac_valid,

  // Configuration levels
  input  logic                         dac_sync,
  input  logic                         dac_format,
  input  data_sel_e [num_channels-1:0] data_sel,
  input  sample_t   [num_channels-1:0] pat_data_0,
  input  sample_t   [num_channels-1:0] pat_data_1,
  output logic      [num_channels-1:0] enable,

  // Link side
  input  logic                         link_ready,
  output logic                         link_valid,
  output lane_t     [num_lanes-1:0]    link_data
);

  pn_beat_t                               pn;
  beat_t    [num_channels-1:0]            ch_data;
  // All channel beats, channel 0 in the MSBs
  logic     [num_channels*beat_width-1:0] frame;

  // ********************
  // PN generator
  // ********************

  tpl_pn_gen tpl_pn_gen_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .sync    (dac_sync),
    .advance (link_ready),
    .pn      (pn)
  );

  // ********************
  // Channels
  // ********************

  for (genvar ch = 0; ch < num_channels; ch++) begin : g_channel
    tpl_dac_channel tpl_dac_channel_inst (
      .clk      (clk),
      .rst_n    (rst_n),
      .ready    (link_ready),
      .data_sel (data_sel[ch]),
      .format   (dac_format),
      .pat_0    (pat_data_0[ch]),
      .pat_1    (pat_data_1[ch]),
      .dma_data (dma_data[ch]),
      .pn       (pn),
      .dma_req  (dac_valid[ch]),
      .enable   (enable[ch]),
      .data     (ch_data[ch])
    );
  end

  // ********************
  // Framer
  // ********************

  // Octet j of the frame, MSB octet first, goes to lane j mod num_lanes
  // at octet slot j div num_lanes counted from the lane MSB
  always_comb begin
    for (int ch = 0; ch < num_channels; ch++) begin
      frame[(num_channels-1-ch)*beat_width +: beat_width] = ch_data[ch];
    end
    for (int j = 0; j < num_channels*beat_width/octet_width; j++) begin
      link_data[j % num_lanes][lane_width-1-octet_width*(j/num_lanes) -: octet_width] =
        frame[num_channels*beat_width-1-octet_width*j -: octet_width];
    end
  end

  // ********************
  // Link valid
  // ********************

  // Low for one clock after any sync cycle, the PN restart needs it
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      link_valid <= 1'b0;
    end else begin
      link_valid <= !dac_sync;
    end
  end

endmodule

//--- test/tpl_dac_tb.sv
// ********************
// Testbench for the JESD204 DAC transport layer
// Directed tests for reset, pattern framing, DMA with format conversion,
// PN sequences, back-pressure and the off and zero sources
// ********************

`timescale 1ns/1ps

module tpl_dac_tb
  import tpl_pkg::*;
();

  localparam int reset_cycles  = 10;
  localparam int pattern_beats = 8;
  localparam int dma_beats     = 24;
  localparam int pn_beats      = 20;
  localparam int stall_cycles  = 6;
  localparam int resume_beats  = 6;
  // All tests take about 100 cycles, so this leaves a wide margin
  localparam int timeout_cycles = 2000;

  localparam sample_t sample_msb = {1'b1, {(sample_width-1){1'b0}}};

  // Both lanes side by side, lane 0 in the LSBs like link_data
  typedef logic [num_lanes*lane_width-1:0] lanes_t;

  logic                         clk;
  logic                         rst_n;
  beat_t     [num_channels-1:0] dma_data;
  logic      [num_channels-1:0] dac_valid;
  logic                         dac_sync;
  logic                         dac_format;
  data_sel_e [num_channels-1:0] data_sel;
  sample_t   [num_channels-1:0] pat_data_0;
  sample_t   [num_channels-1:0] pat_data_1;
  logic      [num_channels-1:0] enable;
  logic                         link_ready;
  logic                         link_valid;
  lane_t     [num_lanes-1:0]    link_data;

  int                   seed;
  int                   err_count;
  int                   tests_run;
  int                   cycle_count;
  // PN model state and the last PN frame on the lanes
  logic [pn7_len-1:0]   ref_pn7;
  logic [pn15_len-1:0]  ref_pn15;
  lanes_t               last_pn_frame;

  tpl_dac_core tpl_dac_core_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .dma_data   (dma_data),
    .dac_valid  (dac_valid),
    .dac_sync   (dac_sync),
    .dac_format (dac_format),
    .data_sel   (data_sel),
    .pat_data_0 (pat_data_0),
    .pat_data_1 (pat_data_1),
    .enable     (enable),
    .link_ready (link_ready),
    .link_valid (link_valid),
    .link_data  (link_data)
  );

  always #5 clk = ~clk;

  // Run limit
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("Run timed out after %0d cycles, a test never got to its end", cycle_count);
      $display("Finished with errors");
      $finish;
    end
  end

  // ********************
  // Reference model
  // ********************

  // MSB flip turns offset binary into two's complement
  function automatic beat_t apply_format(beat_t b, logic fmt);
    beat_t r;
    r = b;
    if (fmt) begin
      r.s0 = b.s0 ^ sample_msb;
      r.s1 = b.s1 ^ sample_msb;
    end
    return r;
  endfunction

  // Octet j of ch0.s0 ch0.s1 ch1.s0 ch1.s1 goes to lane j mod 2, slot j div 2
  function automatic lanes_t frame_lanes(beat_t c0, beat_t c1);
    logic [2*beat_width-1:0] cat;
    lanes_t                  lanes;
    int                      lane;
    int                      slot;
    cat   = {c0.s0, c0.s1, c1.s0, c1.s1};
    lanes = '0;
    for (int j = 0; j < 2*beat_width/octet_width; j++) begin
      lane = j % num_lanes;
      slot = j / num_lanes;
      lanes[lane*lane_width + lane_width - octet_width*(slot+1) +: octet_width] =
        cat[2*beat_width - octet_width*(j+1) +: octet_width];
    end
    return lanes;
  endfunction

  // Next 32 bits of both sequences, each bit is the new feedback bit
  task automatic step_pn_model(output beat_t b7, output beat_t b15);
    logic                  fb;
    logic [beat_width-1:0] bits7;
    logic [beat_width-1:0] bits15;
    bits7  = '0;
    bits15 = '0;
    for (int i = 0; i < beat_width; i++) begin
      // x^7 + x^6 + 1
      fb      = ref_pn7[6] ^ ref_pn7[5];
      ref_pn7 = {ref_pn7[5:0], fb};
      bits7   = {bits7[beat_width-2:0], fb};
      // x^15 + x^14 + 1
      fb       = ref_pn15[14] ^ ref_pn15[13];
      ref_pn15 = {ref_pn15[13:0], fb};
      bits15   = {bits15[beat_width-2:0], fb};
    end
    b7  = bits7;
    b15 = bits15;
  endtask

  task automatic report_error(input string msg);
    err_count++;
    $display("[ERROR] %0t ns: %s", $time, msg);
  endtask

  task automatic close_test(input string name, input int errs_before);
    tests_run++;
    $display("Test %s done, %0d errors", name, err_count - errs_before);
  endtask

  // ********************
  // Directed tests
  // ********************

  task automatic test_reset();
    int errs;
    errs = err_count;
    repeat (reset_cycles) @(negedge clk);
    if (link_valid !== 1'b0 || dac_valid !== '0 || link_data !== '0)
      report_error("outputs not zero in reset");
    rst_n      = 1'b1;
    link_ready = 1'b1;
    @(negedge clk);
    // Sync still high
    if (link_valid !== 1'b0 || dac_valid !== '0 || link_data !== '0)
      report_error("outputs not zero after reset with sync high");
    dac_sync = 1'b0;
    #1;
    if (link_valid !== 1'b0)
      report_error("link_valid high in the first cycle with sync low");
    @(negedge clk);
    if (link_valid !== 1'b1)
      report_error("link_valid low one cycle after sync fell");
    close_test("reset", errs);
  endtask

  task automatic test_pattern();
    int          errs;
    logic [31:0] rnd;
    beat_t       c0;
    beat_t       c1;
    lanes_t      exp;
    errs       = err_count;
    data_sel[0] = sel_pattern;
    data_sel[1] = sel_pattern;
    dac_format = 1'b0;
    for (int i = 0; i < pattern_beats; i++) begin
      for (int ch = 0; ch < num_channels; ch++) begin
        rnd            = $random(seed);
        pat_data_0[ch] = rnd[31:16];
        pat_data_1[ch] = rnd[15:0];
      end
      c0  = {pat_data_0[0], pat_data_1[0]};
      c1  = {pat_data_0[1], pat_data_1[1]};
      exp = frame_lanes(c0, c1);
      @(negedge clk);
      if (link_data !== exp)
        report_error($sformatf("pattern beat %0d: link_data %h, expected %h",
                               i, link_data, exp));
    end
    close_test("pattern_framing", errs);
  endtask

  task automatic test_dma_format();
    int          errs;
    logic [31:0] rnd;
    lanes_t      exp;
    errs        = err_count;
    exp         = '0;
    data_sel[0] = sel_dma;
    data_sel[1] = sel_dma;
    for (int i = 0; i < dma_beats; i++) begin
      rnd         = $random(seed);
      // First beat is always taken so the held value is known
      link_ready  = (i == 0) ? 1'b1 : rnd[0];
      dac_format  = rnd[1];
      dma_data[0] = beat_t'($random(seed));
      dma_data[1] = beat_t'($random(seed));
      #1;
      if (dac_valid !== {num_channels{link_ready}})
        report_error($sformatf("dma beat %0d: dac_valid %b with link_ready %b",
                               i, dac_valid, link_ready));
      if (link_ready)
        exp = frame_lanes(apply_format(dma_data[0], dac_format),
                          apply_format(dma_data[1], dac_format));
      @(negedge clk);
      if (link_data !== exp)
        report_error($sformatf("dma beat %0d: link_data %h, expected %h",
                               i, link_data, exp));
    end
    link_ready = 1'b1;
    close_test("dma_format", errs);
  endtask

  task automatic test_pn();
    int     errs;
    beat_t  b7;
    beat_t  b15;
    lanes_t exp;
    errs        = err_count;
    data_sel[0] = sel_pn7;
    data_sel[1] = sel_pn15;
    dac_format  = 1'b0;
    dac_sync    = 1'b1;
    @(negedge clk);
    dac_sync = 1'b0;
    ref_pn7  = pn_seed7;
    ref_pn15 = pn_seed15;
    for (int i = 0; i < pn_beats; i++) begin
      step_pn_model(b7, b15);
      exp = frame_lanes(b7, b15);
      @(negedge clk);
      if (link_data !== exp)
        report_error($sformatf("pn beat %0d: link_data %h, expected %h",
                               i, link_data, exp));
      if (link_valid !== 1'b1)
        report_error($sformatf("pn beat %0d: link_valid low", i));
    end
    last_pn_frame = exp;
    close_test("pn_sequences", errs);
  endtask

  task automatic test_back_pressure();
    int                      errs;
    beat_t                   b7;
    beat_t                   b15;
    lanes_t                  exp;
    logic [num_channels-1:0] exp_valid;
    errs        = err_count;
    // Channel 1 asks the DMA, so a stalled request would show
    link_ready  = 1'b0;
    data_sel[1] = sel_dma;
    for (int i = 0; i < stall_cycles; i++) begin
      dma_data[1] = beat_t'($random(seed));
      #1;
      if (dac_valid !== '0)
        report_error($sformatf("stall cycle %0d: dac_valid %b", i, dac_valid));
      @(negedge clk);
      if (link_data !== last_pn_frame)
        report_error($sformatf("stall cycle %0d: link_data %h, expected %h",
                               i, link_data, last_pn_frame));
    end
    link_ready = 1'b1;
    for (int i = 0; i < resume_beats; i++) begin
      dma_data[1] = beat_t'($random(seed));
      // Second half checks that PN15 also kept its place
      if (i == resume_beats/2)
        data_sel[1] = sel_pn15;
      step_pn_model(b7, b15);
      exp = frame_lanes(b7, (data_sel[1] == sel_pn15) ? b15 : dma_data[1]);
      exp_valid    = '0;
      exp_valid[1] = (data_sel[1] == sel_dma);
      #1;
      if (dac_valid !== exp_valid)
        report_error($sformatf("resume beat %0d: dac_valid %b, expected %b",
                               i, dac_valid, exp_valid));
      @(negedge clk);
      if (link_data !== exp)
        report_error($sformatf("resume beat %0d: link_data %h, expected %h",
                               i, link_data, exp));
    end
    close_test("back_pressure", errs);
  endtask

  task automatic test_off_zero();
    int                        errs;
    data_sel_e                 sel0 [3];
    data_sel_e                 sel1 [3];
    logic [num_channels-1:0]   exp_en [3];
    errs       = err_count;
    sel0       = '{sel_off, sel_zero, sel_off};
    sel1       = '{sel_off, sel_zero, sel_zero};
    exp_en     = '{2'b00, 2'b11, 2'b10};
    dac_format = 1'b1;
    for (int k = 0; k < 3; k++) begin
      // Live data on the other sources must not leak through
      dma_data[0]   = beat_t'($random(seed));
      dma_data[1]   = beat_t'($random(seed));
      pat_data_0[0] = 16'hffff;
      pat_data_1[1] = 16'h7fff;
      data_sel[0]   = sel0[k];
      data_sel[1]   = sel1[k];
      #1;
      if (enable !== exp_en[k] || dac_valid !== '0)
        report_error($sformatf("case %0d: enable %b, expected %b, dac_valid %b",
                               k, enable, exp_en[k], dac_valid));
      @(negedge clk);
      if (link_data !== '0)
        report_error($sformatf("case %0d: link_data %h, expected zero", k, link_data));
    end
    close_test("off_zero", errs);
  endtask

  // ********************
  // Test sequence
  // ********************

  initial begin
    clk           = 1'b0;
    rst_n         = 1'b0;
    dma_data      = '0;
    dac_sync      = 1'b1;
    dac_format    = 1'b0;
    data_sel[0]   = sel_zero;
    data_sel[1]   = sel_zero;
    pat_data_0    = '0;
    pat_data_1    = '0;
    link_ready    = 1'b0;
    seed          = 32'h57da_c144;
    err_count     = 0;
    tests_run     = 0;
    cycle_count   = 0;
    ref_pn7       = pn_seed7;
    ref_pn15      = pn_seed15;
    last_pn_frame = '0;
    test_reset();
    test_pattern();
    test_dma_format();
    test_pn();
    test_back_pressure();
    test_off_zero();
    $display("Tests run: %0d, errors: %0d", tests_run, err_count);
    if (err_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

//--- build.f
logic/tpl_pkg.sv
logic/tpl_pn_gen.sv
logic/tpl_dac_channel.sv
logic/tpl_dac_core.sv
test/tpl_dac_tb.sv

//--- sim.sh
#!/bin/sh
# Compile and run the transport layer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f build.f \
  --top-module tpl_dac_tb \
  --Mdir obj_dir \
  -o tpl_dac_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator compile failed with status $status"
  exit 1
fi

output=$(./obj_dir/tpl_dac_sim)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "Finished with no errors"; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation did not pass"
  exit 1
fi
